// File: all.f
source/fb_pkg.sv
source/vga_pkg.sv
source/framebuffer_ram.sv
source/scanout_fetch.sv
source/pixel_fifo.sv
source/vga_timing_generator.sv
source/display_top.sv
verif/display_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the display testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f all.f --top-module display_tb -o display_sim \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/display_sim > sim.log 2>&1
cat sim.log

grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// File: verif/display_tb.sv
`timescale 1ns/10ps

module display_tb;

	localparam int H_ACTIVE = 16;
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 3;
	localparam int H_BACK = 3;
	localparam int V_ACTIVE = 8;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 1;
	localparam int FIFO_DEPTH = 8;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int NPIX = H_ACTIVE * V_ACTIVE;	// Words in the frame buffer
	localparam int LATENCY = H_FRONT + H_SYNC + H_BACK + 1;	// Enable to first active pixel
	localparam int TIMEOUT_CYCLES = 3 * H_TOTAL * V_TOTAL + 2 * NPIX + 200;
	localparam int AB = fb_pkg::FB_ADDR_BITS;
	localparam int SEED = 3586;
	localparam int UPD_ADDR = 40;	// Beyond what fetch can prefetch in blanking
	localparam int STOP_PIXEL = 2 * NPIX + 64;	// Mid third frame

	logic clk;
	logic rst_n;
	logic display_en;
	fb_pkg::fb_host_req_t host_req;
	fb_pkg::fb_word_u host_rdata;
	vga_pkg::vga_sync_t vga_sync;
	vga_pkg::vga_rgb_t vga_rgb;

	// Stimulus words and the colour each one should show
	logic [31:0] stim_word [NPIX];
	logic [23:0] exp_rgb [NPIX];

	int err_count = 0;
	int cycle_count = 0;
	bit mon_on = 1'b0;	// Raster monitor running

	// Monitor state
	int pix_idx;	// Next expected raster position
	int pix_checked = 0;	// Active cycles compared so far
	int act_run;
	int hs_run;
	int vs_run;
	int frame_act;	// Active cycles since last vs pulse
	logic prev_blank_n;
	logic prev_hs;
	logic prev_vs;

	display_top #(
		.H_ACTIVE(H_ACTIVE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK),
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.display_en(display_en),
		.host_req(host_req),
		.host_rdata(host_rdata),
		.vga_sync(vga_sync),
		.vga_rgb(vga_rgb)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;	// 20 ns period
	end

	// Hard stop if the sequence stalls
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, the test sequence did not complete", cycle_count);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// BGRA word to displayed colour with r g b from bytes 1, 2 and 3
	function automatic logic [23:0] colour_of(input logic [31:0] w);
		return {w[15:8], w[23:16], w[31:24]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
			err_count++;
		end
	endtask

	task automatic clear_monitor();
		pix_idx = 0;	// Restart means pixel 0
		act_run = 0;
		hs_run = 0;
		vs_run = 0;
		frame_act = 0;
		prev_blank_n = 1'b0;	// Idle output state
		prev_hs = 1'b1;
		prev_vs = 1'b1;
	endtask

	// One sample of the VGA outputs away from the rising edge
	task automatic watch_raster();
		if (vga_sync.blank_n)
		begin
			check_value("vga_rgb", {8'h00, vga_rgb}, {8'h00, exp_rgb[pix_idx]});
			pix_idx = (pix_idx + 1) % NPIX;	// Wraps each frame
			pix_checked++;
			act_run++;
			frame_act++;
		end
		else
		begin
			check_value("vga_rgb in blanking", {8'h00, vga_rgb}, 32'h0);
			if (prev_blank_n)
				check_value("active cycles per line", act_run, H_ACTIVE);
			act_run = 0;
		end
		if (!vga_sync.hs)
			hs_run++;
		else if (!prev_hs)
		begin
			check_value("hs low cycles", hs_run, H_SYNC);
			hs_run = 0;
		end
		if (!vga_sync.vs)
		begin
			if (prev_vs)
			begin
				check_value("active cycles per frame", frame_act, NPIX);	// Falling vs
				frame_act = 0;
			end
			vs_run++;
		end
		else if (!prev_vs)
		begin
			check_value("vs low cycles", vs_run, V_SYNC * H_TOTAL);
			vs_run = 0;
		end
		prev_blank_n = vga_sync.blank_n;
		prev_hs = vga_sync.hs;
		prev_vs = vga_sync.vs;
	endtask

	// Every wait goes through here so the monitor sees each cycle
	task automatic step_cycle();
		@(negedge clk);
		if (mon_on)
			watch_raster();
	endtask

	task automatic drive_write(input int a, input logic [31:0] d);
		host_req.valid = 1'b1;
		host_req.write = 1'b1;
		host_req.addr = AB'(a);
		host_req.wdata.raw = d;
	endtask

	task automatic drive_read(input int a);
		host_req.valid = 1'b1;
		host_req.write = 1'b0;
		host_req.addr = AB'(a);
		host_req.wdata.raw = '0;
	endtask

	task automatic drive_idle();
		host_req = '0;
	endtask

	task automatic run_until_pixels(input int target);
		while (pix_checked < target)
			step_cycle();
	endtask

	// Raise enable and measure the cycles to the first visible pixel
	task automatic start_display();
		int k;
		clear_monitor();
		mon_on = 1'b1;
		display_en = 1'b1;
		k = 0;
		do
		begin
			step_cycle();
			k++;
		end
		while (!vga_sync.blank_n && k < 4 * LATENCY);
		check_value("first blank_n high cycle", k, LATENCY);
	endtask

	initial
	begin
		logic [31:0] new_word;
		int target;
		rst_n = 1'b0;
		display_en = 1'b0;
		host_req = '0;
		void'($urandom(SEED));	// Repeatable table
		for (int i = 0; i < NPIX; i++)
		begin
			stim_word[i] = $urandom();
			exp_rgb[i] = colour_of(stim_word[i]);
		end
		repeat (10) step_cycle();
		rst_n = 1'b1;

		// Load the frame buffer while scanout is stopped
		for (int i = 0; i < NPIX; i++)
		begin
			step_cycle();
			drive_write(i, stim_word[i]);
		end
		step_cycle();
		drive_idle();

		// Readback with data one cycle after each request
		for (int i = 0; i <= NPIX; i++)
		begin
			step_cycle();
			if (i > 0)
				check_value("host_rdata", host_rdata.raw, stim_word[i-1]);
			if (i < NPIX)
				drive_read(i);
			else
				drive_idle();
		end

		start_display();
		run_until_pixels(2 * NPIX);	// Two whole frames

		// Live write after the second frame shows in the next frame
		step_cycle();
		new_word = ~stim_word[UPD_ADDR];
		drive_write(UPD_ADDR, new_word);
		exp_rgb[UPD_ADDR] = colour_of(new_word);
		step_cycle();
		drive_idle();
		run_until_pixels(STOP_PIXEL);

		// Stop mid-frame
		mon_on = 1'b0;
		display_en = 1'b0;
		for (int i = 0; i < 4; i++)
		begin
			step_cycle();
			check_value("blank_n while stopped", 32'(vga_sync.blank_n), 32'h0);
		end

		// Restart must begin at pixel 0 with a clean FIFO and full credits
		target = pix_checked + NPIX;
		start_display();
		run_until_pixels(target);

		$display("scanout checked %0d pixels, %0d errors", pix_checked, err_count);
		if (err_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: source/display_top.sv
`timescale 1ns/10ps

module display_top #(
	parameter int H_ACTIVE = 16,
	parameter int H_FRONT = 2,
	parameter int H_SYNC = 3,
	parameter int H_BACK = 3,
	parameter int V_ACTIVE = 8,
	parameter int V_FRONT = 1,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 1,
	parameter int FIFO_DEPTH = 8
)(
	input logic clk,
	input logic rst_n,
	input logic display_en,	// Scanout run/stop
	input fb_pkg::fb_host_req_t host_req,
	output fb_pkg::fb_word_u host_rdata,
	output vga_pkg::vga_sync_t vga_sync,
	output vga_pkg::vga_rgb_t vga_rgb
);

	logic fetch_rd_en;
	logic [fb_pkg::FB_ADDR_BITS-1:0] fetch_addr;
	fb_pkg::fb_word_u fetch_rdata;
	vga_pkg::pix_push_t pix_push;
	vga_pkg::vga_rgb_t pix_head;
	logic pix_pop;
	logic credit_return;
	logic fifo_flush;

	assign fifo_flush = !display_en;	// Empty the pipe while stopped

	framebuffer_ram #(
		.H_ACTIVE(H_ACTIVE),
		.V_ACTIVE(V_ACTIVE)
	) i_framebuffer_ram (
		.clk(clk),
		.host_req(host_req),
		.fetch_rd_en(fetch_rd_en),
		.fetch_addr(fetch_addr),
		.host_rdata(host_rdata),
		.fetch_rdata(fetch_rdata)
	);

	// Producer, runs ahead by at most FIFO_DEPTH pixels
	scanout_fetch #(
		.H_ACTIVE(H_ACTIVE),
		.V_ACTIVE(V_ACTIVE),
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_scanout_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.display_en(display_en),
		.credit_return(credit_return),
		.fetch_rdata(fetch_rdata),
		.fetch_rd_en(fetch_rd_en),
		.fetch_addr(fetch_addr),
		.pix_push(pix_push)
	);

	pixel_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_pixel_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.flush(fifo_flush),
		.pix_push(pix_push),
		.pix_pop(pix_pop),
		.pix_head(pix_head)
	);

	// Consumer, never stalls
	vga_timing_generator #(
		.H_ACTIVE(H_ACTIVE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) i_vga_timing_generator (
		.clk(clk),
		.rst_n(rst_n),
		.display_en(display_en),
		.pix_head(pix_head),
		.pix_pop(pix_pop),
		.credit_return(credit_return),
		.vga_sync(vga_sync),
		.vga_rgb(vga_rgb)
	);

endmodule

// File: source/vga_timing_generator.sv
`timescale 1ns/10ps

module vga_timing_generator #(
	parameter int H_ACTIVE = 16,
	parameter int H_FRONT = 2,
	parameter int H_SYNC = 3,
	parameter int H_BACK = 3,
	parameter int V_ACTIVE = 8,
	parameter int V_FRONT = 1,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 1
)(
	input logic clk,
	input logic rst_n,
	input logic display_en,
	input vga_pkg::vga_rgb_t pix_head,
	output logic pix_pop,
	output logic credit_return,
	output vga_pkg::vga_sync_t vga_sync,
	output vga_pkg::vga_rgb_t vga_rgb
);

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int HW = $clog2(H_TOTAL);
	localparam int VW = $clog2(V_TOTAL);

	// Line layout is active, front porch, sync, back porch
	localparam logic [HW-1:0] H_ACT_END = HW'(H_ACTIVE);	// Also the idle position
	localparam logic [HW-1:0] H_SYNC_START = HW'(H_ACTIVE + H_FRONT);
	localparam logic [HW-1:0] H_SYNC_END = HW'(H_ACTIVE + H_FRONT + H_SYNC);
	localparam logic [HW-1:0] H_LAST = HW'(H_TOTAL - 1);

	// Frame layout in lines, same order
	localparam logic [VW-1:0] V_ACT_END = VW'(V_ACTIVE);
	localparam logic [VW-1:0] V_SYNC_START = VW'(V_ACTIVE + V_FRONT);
	localparam logic [VW-1:0] V_SYNC_END = VW'(V_ACTIVE + V_FRONT + V_SYNC);
	localparam logic [VW-1:0] V_LAST = VW'(V_TOTAL - 1);

	logic [HW-1:0] h_count;
	logic [VW-1:0] v_count;
	logic active;	// Visible pixel this cycle
	logic hsync_on;
	logic vsync_on;

	// Raster counters
	// Idle parks at front porch of the last blanking line
	always_ff @(posedge clk)
	begin
		if (!rst_n || !display_en)
		begin
			h_count <= H_ACT_END;
			v_count <= V_LAST;
		end
		else if (h_count == H_LAST)
		begin
			h_count <= '0;
			if (v_count == V_LAST)
				v_count <= '0;	// New frame
			else
				v_count <= v_count + VW'(1);
		end
		else
			h_count <= h_count + HW'(1);
	end

	// Decode position
	assign active = display_en && (h_count < H_ACT_END) && (v_count < V_ACT_END);
	assign hsync_on = (h_count >= H_SYNC_START) && (h_count < H_SYNC_END);
	assign vsync_on = (v_count >= V_SYNC_START) && (v_count < V_SYNC_END);	// Whole lines

	// Exactly one pixel consumed per visible cycle
	assign pix_pop = active;

	// Outputs are registered together so colour lines up with blank_n
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			vga_sync.hs <= 1'b1;
			vga_sync.vs <= 1'b1;
			vga_sync.blank_n <= 1'b0;
			vga_rgb <= '0;
			credit_return <= 1'b0;
		end
		else
		begin
			vga_sync.hs <= !hsync_on;
			vga_sync.vs <= !vsync_on;
			vga_sync.blank_n <= active;
			vga_rgb <= active ? pix_head : '0;	// Black in blanking
			credit_return <= pix_pop;	// One credit per popped pixel
		end
	end

endmodule

// File: source/pixel_fifo.sv
`timescale 1ns/10ps

module pixel_fifo #(
	parameter int FIFO_DEPTH = 8
)(
	input logic clk,
	input logic rst_n,
	input logic flush,
	input vga_pkg::pix_push_t pix_push,
	input logic pix_pop,
	output vga_pkg::vga_rgb_t pix_head
);

	localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CW = $clog2(FIFO_DEPTH + 1);
	localparam logic [PW-1:0] LAST_SLOT = PW'(FIFO_DEPTH - 1);

	vga_pkg::vga_rgb_t slots [FIFO_DEPTH];

	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;	// Entries held
	logic full;
	logic empty;

	// Circular pointer step, depth need not be a power of two
	function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
		if (ptr == LAST_SLOT)
			return '0;
		return ptr + PW'(1);
	endfunction

	assign full = (count == CW'(FIFO_DEPTH));
	assign empty = (count == '0);
	assign pix_head = slots[rd_ptr];	// Head visible in the pop cycle

	// Storage
	always_ff @(posedge clk)
	begin
		if (pix_push.valid && !flush)
			slots[wr_ptr] <= pix_push.rgb;
	end

	// Pointers and count, flush wins over push and pop
	always_ff @(posedge clk)
	begin
		if (!rst_n || flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (pix_push.valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (pix_pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + CW'(pix_push.valid) - CW'(pix_pop);
		end
	end

	// Credits in the fetch unit keep both of these from happening
	no_overflow: assert property (
		@(posedge clk) disable iff (!rst_n || flush)
		pix_push.valid |-> !full
	)
	else
		$error("pixel FIFO push while full");

	no_underflow: assert property (
		@(posedge clk) disable iff (!rst_n || flush)
		pix_pop |-> !empty
	)
	else
		$error("pixel FIFO pop while empty");

endmodule

// File: source/scanout_fetch.sv
`timescale 1ns/10ps

module scanout_fetch #(
	parameter int H_ACTIVE = 16,
	parameter int V_ACTIVE = 8,
	parameter int FIFO_DEPTH = 8
)(
	input logic clk,
	input logic rst_n,
	input logic display_en,
	input logic credit_return,
	input fb_pkg::fb_word_u fetch_rdata,
	output logic fetch_rd_en,
	output logic [fb_pkg::FB_ADDR_BITS-1:0] fetch_addr,
	output vga_pkg::pix_push_t pix_push
);

	localparam int AB = fb_pkg::FB_ADDR_BITS;
	localparam int CW = $clog2(FIFO_DEPTH + 1);	// Holds 0 to FIFO_DEPTH
	localparam logic [AB-1:0] LAST_ADDR = AB'(H_ACTIVE * V_ACTIVE - 1);
	localparam logic [CW-1:0] FULL_CREDITS = CW'(FIFO_DEPTH);

	logic [AB-1:0] addr;	// Next pixel to read
	logic [CW-1:0] credits;	// Free FIFO slots not yet claimed
	logic rd_pending;	// RAM data arrives this cycle

	// One read per cycle while a slot is free
	assign fetch_rd_en = display_en && (credits != '0);
	assign fetch_addr = addr;

	// Address walk and credit bookkeeping
	always_ff @(posedge clk)
	begin
		if (!rst_n || !display_en)
		begin
			addr <= '0;	// Restart at pixel 0
			credits <= FULL_CREDITS;	// FIFO is flushed alongside
			rd_pending <= 1'b0;
		end
		else
		begin
			rd_pending <= fetch_rd_en;
			if (fetch_rd_en)
			begin
				if (addr == LAST_ADDR)
					addr <= '0;	// Frame wrap
				else
					addr <= addr + AB'(1);
			end
			// Spend on read, refund on pop
			credits <= credits - CW'(fetch_rd_en) + CW'(credit_return);
		end
	end

	// Decode the returned word as colour fields
	always_comb
	begin
		pix_push.valid = rd_pending;
		pix_push.rgb.r = fetch_rdata.pixel.r;
		pix_push.rgb.g = fetch_rdata.pixel.g;
		pix_push.rgb.b = fetch_rdata.pixel.b;	// Alpha dropped
	end

	// Credits come back only for pixels that were fetched
	credit_bound: assert property (
		@(posedge clk) disable iff (!rst_n)
		credits <= FULL_CREDITS
	)
	else
		$error("credit count %0d above FIFO depth", credits);

endmodule

// File: source/framebuffer_ram.sv
`timescale 1ns/10ps

module framebuffer_ram #(
	parameter int H_ACTIVE = 16,
	parameter int V_ACTIVE = 8
)(
	input logic clk,
	input fb_pkg::fb_host_req_t host_req,
	input logic fetch_rd_en,
	input logic [fb_pkg::FB_ADDR_BITS-1:0] fetch_addr,
	output fb_pkg::fb_word_u host_rdata,
	output fb_pkg::fb_word_u fetch_rdata
);

	localparam int DEPTH = H_ACTIVE * V_ACTIVE;	// One word per visible pixel
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;	// Index bits actually used
	localparam int AB = fb_pkg::FB_ADDR_BITS;
	localparam logic [AB-1:0] ADDR_LIMIT = AB'(DEPTH);	// First illegal address

	fb_pkg::fb_word_u mem [DEPTH];

	logic [AW-1:0] host_idx;
	logic [AW-1:0] fetch_idx;

	assign host_idx = host_req.addr[AW-1:0];
	assign fetch_idx = fetch_addr[AW-1:0];	// Fetch wraps before the limit

	// Host port
	// Write and read share one address, read data is registered
	always_ff @(posedge clk)
	begin
		if (host_req.valid)
		begin
			if (host_req.write)
				mem[host_idx] <= host_req.wdata;
			else
				host_rdata <= mem[host_idx];	// Valid one cycle after request
		end
	end

	// Scanout port is read only
	always_ff @(posedge clk)
	begin
		if (fetch_rd_en)
			fetch_rdata <= mem[fetch_idx];
	end

	// Host must stay inside the visible frame
	host_addr_in_range: assert property (
		@(posedge clk) host_req.valid |-> (host_req.addr < ADDR_LIMIT)
	)
	else
		$error("host access at 0x%0h beyond frame buffer", host_req.addr);

endmodule

// File: source/vga_pkg.sv
package vga_pkg;

	// Colour as it leaves the chip
	typedef struct packed
	{
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} vga_rgb_t;

	// Fetch unit to pixel FIFO
	typedef struct packed
	{
		logic valid;	// Push strobe
		vga_rgb_t rgb;	// Decoded colour
	} pix_push_t;

	// Sync and blanking outputs
	typedef struct packed
	{
		logic hs;	// Active low
		logic vs;	// Active low
		logic blank_n;	// High in active area only
	} vga_sync_t;

endpackage

// File: source/fb_pkg.sv
package fb_pkg;

	// Address width shared by host and scanout ports
	localparam int FB_ADDR_BITS = 16;

	// One stored pixel in BGRA byte order
	typedef struct packed
	{
		logic [7:0] b;	// Top byte
		logic [7:0] g;
		logic [7:0] r;
		logic [7:0] a;	// Alpha is never displayed
	} fb_pixel_t;

	// Frame buffer word
	// Host side moves raw words and scanout reads colour fields
	typedef union packed
	{
		logic [31:0] raw;
		fb_pixel_t pixel;
	} fb_word_u;

	// Host request for one word
	typedef struct packed
	{
		logic valid;	// Request this cycle
		logic write;	// Write when set, read otherwise
		logic [FB_ADDR_BITS-1:0] addr;	// Word address
		fb_word_u wdata;	// Ignored on reads
	} fb_host_req_t;

endpackage
